// File: compile.f
+incdir+testbench
hdl/tanimoto_pkg.sv
hdl/vector_ingest.sv
hdl/threshold_table.sv
hdl/similarity_lane.sv
hdl/pair_merge.sv
hdl/tanimoto_top.sv
testbench/tb_tanimoto.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_tanimoto
FILELIST = compile.f

SIM      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

// File: testbench/tb_tanimoto_model.svh
`ifndef TB_TANIMOTO_MODEL_SVH
`define TB_TANIMOTO_MODEL_SVH

// Bit count of a whole vector, one bit at a time
function automatic int count_ones(input logic [VECTOR_WIDTH-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < VECTOR_WIDTH; i++) begin
        n += int'(v[i]);
    end
    return n;
endfunction

// Expected set from the pair rule, compared with the pairs read in one run
task automatic check_pairs(input int n_vec, input int exp_total);
    int hits [REF_NO][MAX_VEC];
    int r_id;
    int c_id;
    int cnt_a;
    int cnt_b;
    int cnt_ab;
    hits = '{default: 0};
    // Upper byte is the reference ID, lower byte the compared ID
    foreach (pair_q[i]) begin
        r_id = int'(pair_q[i][15:8]);
        c_id = int'(pair_q[i][7:0]);
        if (r_id < REF_NO && c_id >= REF_NO && c_id < n_vec) begin
            hits[r_id][c_id]++;
        end else begin
            check_value(0, 1, $sformatf("pair %h has IDs outside the run", pair_q[i]));
        end
    end
    for (int r = 0; r < REF_NO; r++) begin
        for (int c = REF_NO; c < n_vec; c++) begin
            cnt_a  = count_ones(vec_mem[r]);
            cnt_b  = count_ones(vec_mem[c]);
            cnt_ab = count_ones(vec_mem[r] & vec_mem[c]);
            check_value(hits[r][c], int'(cnt_ab >= thr_model[cnt_a + cnt_b]),
                        $sformatf("times pair ref %0d cmp %0d was read", r, c));
        end
    end
    if (exp_total >= 0) begin
        check_value(pair_q.size(), exp_total, "pairs read in the run");
    end
endtask

`endif

// File: testbench/tb_tanimoto.sv
`timescale 1ns/10ps

module tb_tanimoto;
    import tanimoto_pkg::*;

    localparam int          N_VEC       = 20;
    localparam int          MAX_VEC     = 32;
    localparam int          READY_LIMIT = 2000;
    localparam int          PAIR_LIMIT  = 2000;
    localparam int          STALL_LIMIT = 1000;
    localparam logic [31:0] SEED        = 32'hfa67_5967;

    logic                    clk;
    logic                    rstn;
    logic [BUS_WIDTH-1:0]    i_vector;
    logic                    i_valid;
    logic                    i_last;
    logic                    o_ready;
    logic                    i_thr_we;
    logic [SUM_WIDTH-1:0]    i_thr_addr;
    logic [CNT_WIDTH-1:0]    i_thr_data;
    logic                    o_pair_valid;
    pair_u                   o_pair;
    logic                    o_pair_last;
    logic                    i_pair_read;

    logic [31:0]             rng_state;
    logic [VECTOR_WIDTH-1:0] vec_mem [MAX_VEC];
    int                      thr_model [THR_DEPTH];
    logic [PAIR_WIDTH-1:0]   pair_q [$];
    logic                    sending;
    int                      mismatch_cnt;
    int                      timeout_cnt;

    tanimoto_top dut0 (
        .clk          (clk),
        .rstn         (rstn),
        .i_vector     (i_vector),
        .i_valid      (i_valid),
        .i_last       (i_last),
        .o_ready      (o_ready),
        .i_thr_we     (i_thr_we),
        .i_thr_addr   (i_thr_addr),
        .i_thr_data   (i_thr_data),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair),
        .o_pair_last  (o_pair_last),
        .i_pair_read  (i_pair_read)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    `include "tb_tanimoto_model.svh"

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_and_finish();
        $display("closing report: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        timeout_cnt++;
        $display("timeout at %0t: %s", $time, what);
        report_and_finish();
    endtask

    task automatic program_table(input bit zero_fill);
        for (int a = 0; a < THR_DEPTH; a++) begin
            // Random entries stay between zero and half the address
            if (zero_fill) begin
                thr_model[a] = 0;
            end else begin
                thr_model[a] = int'(next_random() % 32'(a / 2 + 1));
            end
            i_thr_we   = 1'b1;
            i_thr_addr = SUM_WIDTH'(a);
            i_thr_data = CNT_WIDTH'(thr_model[a]);
            @(negedge clk);
        end
        i_thr_we = 1'b0;
    endtask

    task automatic drive_beat(input logic [BUS_WIDTH-1:0] data, input logic last);
        int waited;
        waited   = 0;
        i_valid  = 1'b1;
        i_vector = data;
        i_last   = last;
        // o_ready comes from registers only, so it is settled at the falling edge
        while (!o_ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_ready) begin
            stop_on_timeout("o_ready stayed low and an input beat could not be sent");
        end
        if (last) begin
            sending = 1'b0;
        end
        @(negedge clk);
        i_valid = 1'b0;
        i_last  = 1'b0;
    endtask

    task automatic send_vectors(input int n_vec);
        sending = 1'b1;
        for (int v = 0; v < n_vec; v++) begin
            vec_mem[v] = next_random();
            for (int b = 0; b < SUB_VECTOR_NO; b++) begin
                // Occasional idle cycle between beats
                if ((next_random() % 4) == 0) begin
                    @(negedge clk);
                end
                drive_beat(vec_mem[v][b*BUS_WIDTH +: BUS_WIDTH],
                           (v == n_vec - 1) && (b == SUB_VECTOR_NO - 1));
            end
        end
    endtask

    task automatic read_pairs(input bit stall);
        int waited;
        bit done;
        waited = 0;
        done   = 1'b0;
        if (stall) begin
            // Hold reads back until the lane FIFOs push back on the input
            while (!(sending && !o_ready) && waited < STALL_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!(sending && !o_ready)) begin
                stop_on_timeout("o_ready never dropped while pair reads were held back");
            end
            repeat (30) @(negedge clk);
            check_value(int'(o_ready), 0, "o_ready after a long read pause");
            waited = 0;
        end
        while (!done && waited < PAIR_LIMIT) begin
            i_pair_read = 1'b0;
            if (o_pair_valid && (next_random() % 4) != 0) begin
                i_pair_read = 1'b1;
                waited      = 0;
                if (o_pair_last) begin
                    check_value(int'(o_pair.raw), 0, "end marker word");
                    done = 1'b1;
                end else begin
                    pair_q.push_back(o_pair.raw);
                end
            end else begin
                waited++;
            end
            @(negedge clk);
        end
        i_pair_read = 1'b0;
        if (!done) begin
            stop_on_timeout("no pair and no end marker appeared on the output");
        end
    endtask

    task automatic run_once(input int n_vec, input bit stall, input int exp_total);
        pair_q.delete();
        fork
            send_vectors(n_vec);
            read_pairs(stall);
        join
        // Marker read, so a fresh run is waiting for references
        check_value(int'(o_ready), 1, "o_ready after the end marker was read");
        check_value(int'(o_pair_valid), 0, "o_pair_valid after the end marker was read");
        check_pairs(n_vec, exp_total);
    endtask

    initial begin
        rng_state    = SEED;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        sending      = 1'b0;
        rstn         = 1'b0;
        i_vector     = '0;
        i_valid      = 1'b0;
        i_last       = 1'b0;
        i_thr_we     = 1'b0;
        i_thr_addr   = '0;
        i_thr_data   = '0;
        i_pair_read  = 1'b0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value(int'(o_ready), 1, "o_ready after reset");
        check_value(int'(o_pair_valid), 0, "o_pair_valid after reset");
        check_value(int'(o_pair_last), 0, "o_pair_last after reset");

        // Random thresholds and random read pauses
        program_table(1'b0);
        run_once(N_VEC, 1'b0, -1);

        // Zero thresholds pass every pair
        // Reads pause until the input is stalled
        program_table(1'b1);
        run_once(N_VEC, 1'b1, REF_NO * (N_VEC - REF_NO));

        // Another run with new references
        program_table(1'b0);
        run_once(N_VEC, 1'b0, -1);

        report_and_finish();
    end

endmodule

// File: hdl/tanimoto_top.sv
`timescale 1ns/10ps

module tanimoto_top (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [tanimoto_pkg::BUS_WIDTH-1:0]   i_vector,
    input  logic                                 i_valid,
    input  logic                                 i_last,
    output logic                                 o_ready,
    input  logic                                 i_thr_we,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_thr_addr,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_thr_data,
    output logic                                 o_pair_valid,
    output tanimoto_pkg::pair_u                  o_pair,
    output logic                                 o_pair_last,
    input  logic                                 i_pair_read
);
    import tanimoto_pkg::*;

    // Registered beat bus from ingest to every lane
    logic [BUS_WIDTH-1:0]      w_beat;
    logic [BEAT_IDX_WIDTH-1:0] w_beat_idx;
    logic                      w_ref_we;
    logic [REF_IDX_WIDTH-1:0]  w_ref_lane;
    logic                      w_cmp_we;
    logic                      w_vec_done;
    logic [CNT_WIDTH-1:0]      w_vec_cnt;
    logic [VEC_ID_WIDTH-1:0]   w_vec_id;
    logic                      w_over;

    logic [SUM_WIDTH-1:0]      w_thr_addr [REF_NO];
    logic [CNT_WIDTH-1:0]      w_thr_min [REF_NO];
    logic [REF_NO-1:0]         w_fifo_valid;
    pair_u                     w_fifo_data [REF_NO];
    logic [REF_NO-1:0]         w_fifo_pop;
    logic [REF_NO-1:0]         w_almost_full;
    logic [REF_NO-1:0]         w_idle;
    logic                      w_halt;
    logic                      w_lanes_idle;

    // Any lane close to full stalls the input
    assign w_halt       = |w_almost_full;
    assign w_lanes_idle = &w_idle;

    vector_ingest u_ingest (
        .clk          (clk),
        .rstn         (rstn),
        .i_vector     (i_vector),
        .i_valid      (i_valid),
        .i_last       (i_last),
        .i_halt       (w_halt),
        .i_lanes_idle (w_lanes_idle),
        .i_pair_read  (i_pair_read),
        .o_ready      (o_ready),
        .o_beat       (w_beat),
        .o_beat_idx   (w_beat_idx),
        .o_ref_we     (w_ref_we),
        .o_ref_lane   (w_ref_lane),
        .o_cmp_we     (w_cmp_we),
        .o_vec_done   (w_vec_done),
        .o_vec_cnt    (w_vec_cnt),
        .o_vec_id     (w_vec_id),
        .o_over       (w_over)
    );

    threshold_table u_thr_table (
        .clk       (clk),
        .rstn      (rstn),
        .i_we      (i_thr_we),
        .i_addr    (i_thr_addr),
        .i_data    (i_thr_data),
        .i_rd_addr (w_thr_addr),
        .o_rd_data (w_thr_min)
    );

    for (genvar g = 0; g < REF_NO; g++) begin : g_lane
        similarity_lane #(
            .LANE_ID (g)
        ) u_lane (
            .clk           (clk),
            .rstn          (rstn),
            .i_beat        (w_beat),
            .i_beat_idx    (w_beat_idx),
            .i_ref_we      (w_ref_we),
            .i_ref_lane    (w_ref_lane),
            .i_cmp_we      (w_cmp_we),
            .i_vec_done    (w_vec_done),
            .i_vec_cnt     (w_vec_cnt),
            .i_vec_id      (w_vec_id),
            .i_thr_min     (w_thr_min[g]),
            .i_fifo_pop    (w_fifo_pop[g]),
            .o_thr_addr    (w_thr_addr[g]),
            .o_fifo_valid  (w_fifo_valid[g]),
            .o_fifo_data   (w_fifo_data[g]),
            .o_almost_full (w_almost_full[g]),
            .o_idle        (w_idle[g])
        );
    end

    pair_merge u_merge (
        .clk          (clk),
        .rstn         (rstn),
        .i_fifo_valid (w_fifo_valid),
        .i_fifo_data  (w_fifo_data),
        .o_fifo_pop   (w_fifo_pop),
        .i_over       (w_over),
        .i_pair_read  (i_pair_read),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair),
        .o_pair_last  (o_pair_last)
    );

endmodule

// File: hdl/pair_merge.sv
`timescale 1ns/10ps

module pair_merge (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [tanimoto_pkg::REF_NO-1:0] i_fifo_valid,
    input  tanimoto_pkg::pair_u             i_fifo_data [tanimoto_pkg::REF_NO],
    output logic [tanimoto_pkg::REF_NO-1:0] o_fifo_pop,
    input  logic                            i_over,
    input  logic                            i_pair_read,
    output logic                            o_pair_valid,
    output tanimoto_pkg::pair_u             o_pair,
    output logic                            o_pair_last
);
    import tanimoto_pkg::*;

    logic [REF_IDX_WIDTH-1:0] r_last_lane;
    logic [REF_IDX_WIDTH-1:0] w_sel;
    logic                     w_found;

    // Round-robin search, starting one past the lane served last
    always_comb begin
        logic [REF_IDX_WIDTH-1:0] idx;
        w_found = 1'b0;
        w_sel   = r_last_lane;
        for (int k = 1; k <= REF_NO; k++) begin
            idx = REF_IDX_WIDTH'((int'(r_last_lane) + k) % REF_NO);
            if (!w_found && i_fifo_valid[idx]) begin
                w_found = 1'b1;
                w_sel   = idx;
            end
        end
    end

    // End marker overrides the FIFO heads
    assign o_pair_valid = i_over || w_found;
    assign o_pair_last  = i_over;
    assign o_pair.raw   = i_over ? '0 : i_fifo_data[w_sel].raw;

    for (genvar g = 0; g < REF_NO; g++) begin : g_pop
        assign o_fifo_pop[g] = !i_over && w_found && i_pair_read
                               && (w_sel == REF_IDX_WIDTH'(g));
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_last_lane <= REF_IDX_WIDTH'(REF_NO - 1);
        end else if (|o_fifo_pop) begin
            r_last_lane <= w_sel;
        end
    end

endmodule

// File: hdl/similarity_lane.sv
`timescale 1ns/10ps

module similarity_lane #(
    parameter int LANE_ID = 0
) (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic [tanimoto_pkg::BUS_WIDTH-1:0]      i_beat,
    input  logic [tanimoto_pkg::BEAT_IDX_WIDTH-1:0] i_beat_idx,
    input  logic                                    i_ref_we,
    input  logic [tanimoto_pkg::REF_IDX_WIDTH-1:0]  i_ref_lane,
    input  logic                                    i_cmp_we,
    input  logic                                    i_vec_done,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]      i_vec_cnt,
    input  logic [tanimoto_pkg::VEC_ID_WIDTH-1:0]   i_vec_id,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]      i_thr_min,
    input  logic                                    i_fifo_pop,
    output logic [tanimoto_pkg::SUM_WIDTH-1:0]      o_thr_addr,
    output logic                                    o_fifo_valid,
    output tanimoto_pkg::pair_u                     o_fifo_data,
    output logic                                    o_almost_full,
    output logic                                    o_idle
);
    import tanimoto_pkg::*;

    // Reference store
    logic [BUS_WIDTH-1:0]      r_ref_beat [SUB_VECTOR_NO];
    logic [CNT_WIDTH-1:0]      r_cnt_a;
    logic [VEC_ID_WIDTH-1:0]   r_ref_id;

    // Running AND count of the compared vector
    logic [CNT_WIDTH-1:0]      r_ab_acc;
    logic [CNT_WIDTH-1:0]      w_ab_sum;

    // Pipeline stages
    logic                      r_s1_valid;
    logic [CNT_WIDTH-1:0]      r_s1_cnt_ab;
    logic [SUM_WIDTH-1:0]      r_s1_sum;
    pair_u                     r_s1_pair;
    logic                      r_s2_valid;
    logic                      r_s2_match;
    pair_u                     r_s2_pair;

    // Result FIFO
    logic [PAIR_WIDTH-1:0]     r_mem [LANE_FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] r_wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] r_rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] r_count;
    logic                      w_ref_sel;
    logic                      w_push;
    logic                      w_pop;

    assign w_ref_sel = i_ref_we && (i_ref_lane == REF_IDX_WIDTH'(LANE_ID));
    // First beat restarts the count
    assign w_ab_sum  = ((i_beat_idx == '0) ? '0 : r_ab_acc)
                       + popcount(r_ref_beat[i_beat_idx] & i_beat);

    always_ff @(posedge clk) begin
        if (w_ref_sel) begin
            r_ref_beat[i_beat_idx] <= i_beat;
            if (i_vec_done) begin
                r_cnt_a  <= i_vec_cnt;
                r_ref_id <= i_vec_id;
            end
        end
        if (i_cmp_we) begin
            r_ab_acc <= w_ab_sum;
        end
    end

    // Stage 1 holds cnt_ab, the table address and the ID pair
    always_ff @(posedge clk) begin
        if (i_cmp_we && i_vec_done) begin
            r_s1_cnt_ab      <= w_ab_sum;
            r_s1_sum         <= SUM_WIDTH'(r_cnt_a) + SUM_WIDTH'(i_vec_cnt);
            r_s1_pair.f.ref_id <= r_ref_id;
            r_s1_pair.f.cmp_id <= i_vec_id;
        end
        r_s2_match <= (r_s1_cnt_ab >= i_thr_min);
        r_s2_pair  <= r_s1_pair;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_s1_valid <= 1'b0;
            r_s2_valid <= 1'b0;
        end else begin
            r_s1_valid <= i_cmp_we && i_vec_done;
            r_s2_valid <= r_s1_valid;
        end
    end

    assign o_thr_addr = r_s1_sum;

    // Stage 2 pushes matching pairs
    assign w_push = r_s2_valid && r_s2_match;
    assign w_pop  = i_fifo_pop && o_fifo_valid;

    always_ff @(posedge clk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= r_s2_pair.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    assign o_fifo_valid     = (r_count != '0);
    assign o_fifo_data.raw  = r_mem[r_rd_ptr];
    // Fewer than FIFO_MARGIN free slots
    assign o_almost_full    = (r_count > FIFO_CNT_WIDTH'(LANE_FIFO_DEPTH - FIFO_MARGIN));
    assign o_idle           = !r_s1_valid && !r_s2_valid && !o_fifo_valid;

endmodule

// File: hdl/threshold_table.sv
`timescale 1ns/10ps

module threshold_table (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               i_we,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0] i_addr,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0] i_data,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0] i_rd_addr [tanimoto_pkg::REF_NO],
    output logic [tanimoto_pkg::CNT_WIDTH-1:0] o_rd_data [tanimoto_pkg::REF_NO]
);
    import tanimoto_pkg::*;

    logic [CNT_WIDTH-1:0] r_thr [THR_DEPTH];

    // All ones is above any possible AND count, so nothing matches until programmed
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < THR_DEPTH; i++) begin
                r_thr[i] <= '1;
            end
        end else if (i_we && i_addr < SUM_WIDTH'(THR_DEPTH)) begin
            r_thr[i_addr] <= i_data;
        end
    end

    // One read port per lane
    for (genvar g = 0; g < REF_NO; g++) begin : g_rd
        assign o_rd_data[g] = r_thr[i_rd_addr[g]];
    end

endmodule

// File: hdl/vector_ingest.sv
`timescale 1ns/10ps

module vector_ingest (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic [tanimoto_pkg::BUS_WIDTH-1:0]      i_vector,
    input  logic                                    i_valid,
    input  logic                                    i_last,
    input  logic                                    i_halt,
    input  logic                                    i_lanes_idle,
    input  logic                                    i_pair_read,
    output logic                                    o_ready,
    output logic [tanimoto_pkg::BUS_WIDTH-1:0]      o_beat,
    output logic [tanimoto_pkg::BEAT_IDX_WIDTH-1:0] o_beat_idx,
    output logic                                    o_ref_we,
    output logic [tanimoto_pkg::REF_IDX_WIDTH-1:0]  o_ref_lane,
    output logic                                    o_cmp_we,
    output logic                                    o_vec_done,
    output logic [tanimoto_pkg::CNT_WIDTH-1:0]      o_vec_cnt,
    output logic [tanimoto_pkg::VEC_ID_WIDTH-1:0]   o_vec_id,
    output logic                                    o_over
);
    import tanimoto_pkg::*;

    logic [1:0]                r_state;
    logic [BEAT_IDX_WIDTH-1:0] r_beat_idx;
    logic [VEC_ID_WIDTH-1:0]   r_vec_id;
    logic [CNT_WIDTH-1:0]      r_cnt_acc;
    logic                      w_accept;
    logic                      w_last_beat;
    logic                      w_is_ref;
    logic [CNT_WIDTH-1:0]      w_cnt_sum;

    assign o_ready     = !i_halt && (r_state == ST_LOAD || r_state == ST_COMPARE);
    assign o_over      = (r_state == ST_OVER);
    assign w_accept    = i_valid && o_ready;
    assign w_last_beat = (r_beat_idx == BEAT_IDX_WIDTH'(SUB_VECTOR_NO - 1));
    assign w_is_ref    = (r_vec_id < VEC_ID_WIDTH'(REF_NO));
    assign w_cnt_sum   = r_cnt_acc + popcount(i_vector);

    // Beat position, vector ID, running bit count and run state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_state    <= ST_LOAD;
            r_beat_idx <= '0;
            r_vec_id   <= '0;
            r_cnt_acc  <= '0;
        end else if (r_state == ST_OVER) begin
            // Reading the end marker starts a new run
            if (i_pair_read) begin
                r_state    <= ST_LOAD;
                r_beat_idx <= '0;
                r_vec_id   <= '0;
                r_cnt_acc  <= '0;
            end
        end else if (r_state == ST_FLUSH) begin
            // Last vector must have left the beat bus before the lanes count
            if (i_lanes_idle && !o_vec_done) begin
                r_state <= ST_OVER;
            end
        end else if (w_accept) begin
            if (w_last_beat) begin
                r_beat_idx <= '0;
                r_cnt_acc  <= '0;
                r_vec_id   <= r_vec_id + 1'b1;
            end else begin
                r_beat_idx <= r_beat_idx + 1'b1;
                r_cnt_acc  <= w_cnt_sum;
            end
            if (i_last) begin
                r_state <= ST_FLUSH;
            end else if (w_last_beat && r_vec_id == VEC_ID_WIDTH'(REF_NO - 1)) begin
                r_state <= ST_COMPARE;
            end
        end
    end

    // Beat bus strobes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_ref_we   <= 1'b0;
            o_cmp_we   <= 1'b0;
            o_vec_done <= 1'b0;
        end else begin
            o_ref_we   <= w_accept && w_is_ref;
            o_cmp_we   <= w_accept && !w_is_ref;
            o_vec_done <= w_accept && w_last_beat;
        end
    end

    // Beat bus payload, only meaningful alongside a strobe
    always_ff @(posedge clk) begin
        if (w_accept) begin
            o_beat     <= i_vector;
            o_beat_idx <= r_beat_idx;
            o_ref_lane <= r_vec_id[REF_IDX_WIDTH-1:0];
            o_vec_cnt  <= w_cnt_sum;
            o_vec_id   <= r_vec_id;
        end
    end

endmodule

// File: hdl/tanimoto_pkg.sv
package tanimoto_pkg;

    // Stream and vector geometry
    localparam int BUS_WIDTH       = 16;
    localparam int VECTOR_WIDTH    = 32;
    localparam int SUB_VECTOR_NO   = VECTOR_WIDTH / BUS_WIDTH;
    localparam int REF_NO          = 4;
    localparam int VEC_ID_WIDTH    = 8;

    // Bit counts and threshold table
    localparam int CNT_WIDTH       = $clog2(VECTOR_WIDTH + 1);
    localparam int SUM_WIDTH       = $clog2(2 * VECTOR_WIDTH + 1);
    localparam int THR_DEPTH       = 2 * VECTOR_WIDTH + 1;

    // Lane result FIFO
    localparam int LANE_FIFO_DEPTH = 8;
    localparam int FIFO_MARGIN     = 3;
    localparam int FIFO_PTR_WIDTH  = $clog2(LANE_FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH  = $clog2(LANE_FIFO_DEPTH + 1);

    // Derived index widths
    localparam int BEAT_IDX_WIDTH  = (SUB_VECTOR_NO > 1) ? $clog2(SUB_VECTOR_NO) : 1;
    localparam int REF_IDX_WIDTH   = (REF_NO > 1) ? $clog2(REF_NO) : 1;
    localparam int PAIR_WIDTH      = 2 * VEC_ID_WIDTH;

    // Run states
    localparam logic [1:0] ST_LOAD    = 2'b00;
    localparam logic [1:0] ST_COMPARE = 2'b01;
    localparam logic [1:0] ST_FLUSH   = 2'b10;
    localparam logic [1:0] ST_OVER    = 2'b11;

    typedef struct packed {
        logic [VEC_ID_WIDTH-1:0] ref_id;
        logic [VEC_ID_WIDTH-1:0] cmp_id;
    } pair_fields_t;

    // Built from two IDs, stored and emitted as one word
    typedef union packed {
        pair_fields_t            f;
        logic [PAIR_WIDTH-1:0]   raw;
    } pair_u;

    function automatic logic [CNT_WIDTH-1:0] popcount(input logic [BUS_WIDTH-1:0] beat);
        logic [CNT_WIDTH-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < BUS_WIDTH; i++) begin
            cnt = cnt + CNT_WIDTH'(beat[i]);
        end
        return cnt;
    endfunction

endpackage
